// File: hdl/sha512_cfg.svh
`ifndef SHA512_CFG_SVH
`define SHA512_CFG_SVH

// byte address width of the register port.
`define SHA512_ADDR_W 10
// bus word width.
`define SHA512_DATA_W 32

// one 1024-bit block as bus words.
`define SHA512_BLOCK_WORDS 32
`define SHA512_ROUNDS 80

`endif

// File: hdl/sha512_pkg.sv
`default_nettype none

`include "sha512_cfg.svh"

package sha512_pkg;

  typedef enum logic [1:0] {
    mode_224 = 2'd0,
    mode_256 = 2'd1,
    mode_384 = 2'd2,
    mode_512 = 2'd3
  } sha512_mode_t;

  typedef enum logic [1:0] {
    idle,
    init_round,
    rounds,
    finalize
  } sha512_state_t;

  typedef logic [`SHA512_BLOCK_WORDS*`SHA512_DATA_W-1:0] sha512_block_t;
  typedef logic [511:0] sha512_digest_t;

  function automatic logic [63:0] rotr64(input logic [63:0] x, input int unsigned n);
    return (x >> n) | (x << (64 - n));
  endfunction

endpackage

`default_nettype wire

// File: hdl/sha512_axil_pkg.sv
`default_nettype none

package sha512_axil_pkg;

  typedef enum logic [1:0] {
    axil_okay   = 2'b00,
    axil_slverr = 2'b10
  } axil_resp_t;

  // word offsets, byte address divided by four.
  localparam int unsigned reg_ctrl      = 8;
  localparam int unsigned reg_status    = 9;
  localparam int unsigned reg_block_lo  = 16;
  localparam int unsigned reg_block_hi  = 47;
  localparam int unsigned reg_digest_lo = 64;
  localparam int unsigned reg_digest_hi = 79;

endpackage

`default_nettype wire

// File: hdl/sha512_core_if.sv
`timescale 1ns/100ps
`default_nettype none

interface sha512_core_if
  import sha512_pkg::*;
();
  sha512_block_t  block;
  sha512_mode_t   mode;
  logic           init;
  logic           next;
  logic           ready;
  logic           digest_valid;
  sha512_digest_t digest;

  modport regs (output block, mode, init, next, input ready, digest_valid, digest);
  modport core (input block, mode, init, next, output ready, digest_valid, digest);

endinterface

`default_nettype wire

// File: hdl/sha512_h_constants.sv
`timescale 1ns/100ps
`default_nettype none

module sha512_h_constants
  import sha512_pkg::*;
(
  input  sha512_mode_t   mode,
  output sha512_digest_t h
);

  // H0 sits in the top 64 bits.
  always_comb
  begin
    case (mode)
      mode_224:
        h = {64'h8c3d37c819544da2, 64'h73e1996689dcd4d6,
             64'h1dfab7ae32ff9c82, 64'h679dd514582f9fcf,
             64'h0f6d2b697bd44da8, 64'h77e36f7304c48942,
             64'h3f9d85a86a1d36c8, 64'h1112e6ad91d692a1};
      mode_256:
        h = {64'h22312194fc2bf72c, 64'h9f555fa3c84c64c2,
             64'h2393b86b6f53b151, 64'h963877195940eabd,
             64'h96283ee2a88effe3, 64'hbe5e1e2553863992,
             64'h2b0199fc2c85b8aa, 64'h0eb72ddc81c52ca2};
      mode_384:
        h = {64'hcbbb9d5dc1059ed8, 64'h629a292a367cd507,
             64'h9159015a3070dd17, 64'h152fecd8f70e5939,
             64'h67332667ffc00b31, 64'h8eb44a8768581511,
             64'hdb0c2e0d64f98fa7, 64'h47b5481dbefa4fa4};
      default:
        h = {64'h6a09e667f3bcc908, 64'hbb67ae8584caa73b,
             64'h3c6ef372fe94f82b, 64'ha54ff53a5f1d36f1,
             64'h510e527fade682d1, 64'h9b05688c2b3e6c1f,
             64'h1f83d9abfb41bd6b, 64'h5be0cd19137e2179};
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/sha512_k_constants.sv
`timescale 1ns/100ps
`default_nettype none

module sha512_k_constants (
  input  logic [6:0]  round,
  output logic [63:0] k
);

  always_comb
  begin
    case (round)
      7'd0:  k = 64'h428a2f98d728ae22;
      7'd1:  k = 64'h7137449123ef65cd;
      7'd2:  k = 64'hb5c0fbcfec4d3b2f;
      7'd3:  k = 64'he9b5dba58189dbbc;
      7'd4:  k = 64'h3956c25bf348b538;
      7'd5:  k = 64'h59f111f1b605d019;
      7'd6:  k = 64'h923f82a4af194f9b;
      7'd7:  k = 64'hab1c5ed5da6d8118;
      7'd8:  k = 64'hd807aa98a3030242;
      7'd9:  k = 64'h12835b0145706fbe;
      7'd10: k = 64'h243185be4ee4b28c;
      7'd11: k = 64'h550c7dc3d5ffb4e2;
      7'd12: k = 64'h72be5d74f27b896f;
      7'd13: k = 64'h80deb1fe3b1696b1;
      7'd14: k = 64'h9bdc06a725c71235;
      7'd15: k = 64'hc19bf174cf692694;
      7'd16: k = 64'he49b69c19ef14ad2;
      7'd17: k = 64'hefbe4786384f25e3;
      7'd18: k = 64'h0fc19dc68b8cd5b5;
      7'd19: k = 64'h240ca1cc77ac9c65;
      7'd20: k = 64'h2de92c6f592b0275;
      7'd21: k = 64'h4a7484aa6ea6e483;
      7'd22: k = 64'h5cb0a9dcbd41fbd4;
      7'd23: k = 64'h76f988da831153b5;
      7'd24: k = 64'h983e5152ee66dfab;
      7'd25: k = 64'ha831c66d2db43210;
      7'd26: k = 64'hb00327c898fb213f;
      7'd27: k = 64'hbf597fc7beef0ee4;
      7'd28: k = 64'hc6e00bf33da88fc2;
      7'd29: k = 64'hd5a79147930aa725;
      7'd30: k = 64'h06ca6351e003826f;
      7'd31: k = 64'h142929670a0e6e70;
      7'd32: k = 64'h27b70a8546d22ffc;
      7'd33: k = 64'h2e1b21385c26c926;
      7'd34: k = 64'h4d2c6dfc5ac42aed;
      7'd35: k = 64'h53380d139d95b3df;
      7'd36: k = 64'h650a73548baf63de;
      7'd37: k = 64'h766a0abb3c77b2a8;
      7'd38: k = 64'h81c2c92e47edaee6;
      7'd39: k = 64'h92722c851482353b;
      7'd40: k = 64'ha2bfe8a14cf10364;
      7'd41: k = 64'ha81a664bbc423001;
      7'd42: k = 64'hc24b8b70d0f89791;
      7'd43: k = 64'hc76c51a30654be30;
      7'd44: k = 64'hd192e819d6ef5218;
      7'd45: k = 64'hd69906245565a910;
      7'd46: k = 64'hf40e35855771202a;
      7'd47: k = 64'h106aa07032bbd1b8;
      7'd48: k = 64'h19a4c116b8d2d0c8;
      7'd49: k = 64'h1e376c085141ab53;
      7'd50: k = 64'h2748774cdf8eeb99;
      7'd51: k = 64'h34b0bcb5e19b48a8;
      7'd52: k = 64'h391c0cb3c5c95a63;
      7'd53: k = 64'h4ed8aa4ae3418acb;
      7'd54: k = 64'h5b9cca4f7763e373;
      7'd55: k = 64'h682e6ff3d6b2b8a3;
      7'd56: k = 64'h748f82ee5defb2fc;
      7'd57: k = 64'h78a5636f43172f60;
      7'd58: k = 64'h84c87814a1f0ab72;
      7'd59: k = 64'h8cc702081a6439ec;
      7'd60: k = 64'h90befffa23631e28;
      7'd61: k = 64'ha4506cebde82bde9;
      7'd62: k = 64'hbef9a3f7b2c67915;
      7'd63: k = 64'hc67178f2e372532b;
      7'd64: k = 64'hca273eceea26619c;
      7'd65: k = 64'hd186b8c721c0c207;
      7'd66: k = 64'heada7dd6cde0eb1e;
      7'd67: k = 64'hf57d4f7fee6ed178;
      7'd68: k = 64'h06f067aa72176fba;
      7'd69: k = 64'h0a637dc5a2c898a6;
      7'd70: k = 64'h113f9804bef90dae;
      7'd71: k = 64'h1b710b35131c471b;
      7'd72: k = 64'h28db77f523047d84;
      7'd73: k = 64'h32caab7b40c72493;
      7'd74: k = 64'h3c9ebe0a15c9bebc;
      7'd75: k = 64'h431d67c49c100d4c;
      7'd76: k = 64'h4cc5d4becb3e42b6;
      7'd77: k = 64'h597f299cfc657e2a;
      7'd78: k = 64'h5fcb6fab3ad6faec;
      7'd79: k = 64'h6c44198c4a475817;
      default: k = 64'h0;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/sha512_w_mem.sv
`timescale 1ns/100ps
`default_nettype none

module sha512_w_mem
  import sha512_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  input  sha512_block_t block,
  input  logic          load,
  input  logic          step,
  output logic [63:0]   w
);

  // window holds W[t] .. W[t+15], W[t] at index 0.
  logic [63:0] win_q [16];
  logic [63:0] s0;
  logic [63:0] s1;
  logic [63:0] w_new;

  assign s0 = rotr64(win_q[1], 1) ^ rotr64(win_q[1], 8) ^ (win_q[1] >> 7);
  assign s1 = rotr64(win_q[14], 19) ^ rotr64(win_q[14], 61) ^ (win_q[14] >> 6);
  assign w_new = s1 + win_q[9] + s0 + win_q[0];

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < 16; i++)
        win_q[i] <= '0;
    end
    else if (load)
    begin
      for (int i = 0; i < 16; i++)
        win_q[i] <= block[1023 - 64*i -: 64];
    end
    else if (step)
    begin
      for (int i = 0; i < 15; i++)
        win_q[i] <= win_q[i+1];
      win_q[15] <= w_new;
    end
  end

  assign w = win_q[0];

endmodule

`default_nettype wire

// File: hdl/sha512_core.sv
`timescale 1ns/100ps
`default_nettype none

`include "sha512_cfg.svh"

module sha512_core
  import sha512_pkg::*;
(
  input logic         clk,
  input logic         rst_n,
  sha512_core_if.core bus
);

  sha512_state_t  state_q;
  sha512_mode_t   mode_q;
  logic           is_init_q;
  logic           dv_q;
  logic [6:0]     round_q;
  logic [63:0]    h_q [8];
  logic [63:0]    v_q [8];
  sha512_digest_t h_init;
  sha512_digest_t full;
  logic [63:0]    k;
  logic [63:0]    w;
  logic [63:0]    t1;
  logic [63:0]    t2;
  logic           start;

  sha512_h_constants u_h (.mode(mode_q), .h(h_init));
  sha512_k_constants u_k (.round(round_q), .k(k));

  // the window loads at the start pulse and advances once per round.
  sha512_w_mem u_w (
    .clk  (clk),
    .rst_n(rst_n),
    .block(bus.block),
    .load (start),
    .step (state_q == rounds),
    .w    (w)
  );

  assign start = bus.ready && (bus.init || bus.next);

  assign t1 = v_q[7] + (rotr64(v_q[4], 14) ^ rotr64(v_q[4], 18) ^ rotr64(v_q[4], 41))
            + ((v_q[4] & v_q[5]) ^ (~v_q[4] & v_q[6])) + k + w;
  assign t2 = (rotr64(v_q[0], 28) ^ rotr64(v_q[0], 34) ^ rotr64(v_q[0], 39))
            + ((v_q[0] & v_q[1]) ^ (v_q[0] & v_q[2]) ^ (v_q[1] & v_q[2]));

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q   <= idle;
      mode_q    <= mode_512;
      is_init_q <= 1'b0;
      dv_q      <= 1'b0;
      round_q   <= '0;
    end
    else
    begin
      case (state_q)
        idle:
          if (start)
          begin
            state_q   <= init_round;
            dv_q      <= 1'b0;
            is_init_q <= bus.init;
            // next keeps the mode of the message's first block.
            if (bus.init)
              mode_q <= bus.mode;
          end
        init_round:
        begin
          round_q <= '0;
          state_q <= rounds;
        end
        rounds:
        begin
          round_q <= round_q + 7'd1;
          if (round_q == 7'(`SHA512_ROUNDS - 1))
            state_q <= finalize;
        end
        default:
        begin
          dv_q    <= 1'b1;
          state_q <= idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    case (state_q)
      init_round:
        for (int i = 0; i < 8; i++)
        begin
          if (is_init_q)
          begin
            h_q[i] <= h_init[511 - 64*i -: 64];
            v_q[i] <= h_init[511 - 64*i -: 64];
          end
          else
            v_q[i] <= h_q[i];
        end
      rounds:
      begin
        v_q[0] <= t1 + t2;
        v_q[1] <= v_q[0];
        v_q[2] <= v_q[1];
        v_q[3] <= v_q[2];
        v_q[4] <= v_q[3] + t1;
        v_q[5] <= v_q[4];
        v_q[6] <= v_q[5];
        v_q[7] <= v_q[6];
      end
      finalize:
        for (int i = 0; i < 8; i++)
          h_q[i] <= h_q[i] + v_q[i];
      default:
        ;
    endcase
  end

  assign full = {h_q[0], h_q[1], h_q[2], h_q[3], h_q[4], h_q[5], h_q[6], h_q[7]};

  // truncated modes read zero past their length.
  always_comb
  begin
    case (mode_q)
      mode_224: bus.digest = {full[511:288], 288'h0};
      mode_256: bus.digest = {full[511:256], 256'h0};
      mode_384: bus.digest = {full[511:128], 128'h0};
      default:  bus.digest = full;
    endcase
  end

  assign bus.ready        = (state_q == idle);
  assign bus.digest_valid = dv_q;

  a_busy_after_start: assert property (@(posedge clk) disable iff (!rst_n)
    start |=> !bus.ready);

  a_valid_only_ready: assert property (@(posedge clk) disable iff (!rst_n)
    bus.digest_valid |-> bus.ready);

endmodule

`default_nettype wire

// File: hdl/sha512_axil_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "sha512_cfg.svh"

module sha512_axil_regs
  import sha512_pkg::*;
  import sha512_axil_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [`SHA512_ADDR_W-1:0]   awaddr,
  input  logic                        awvalid,
  output logic                        awready,
  input  logic [`SHA512_DATA_W-1:0]   wdata,
  input  logic [`SHA512_DATA_W/8-1:0] wstrb,
  input  logic                        wvalid,
  output logic                        wready,
  output axil_resp_t                  bresp,
  output logic                        bvalid,
  input  logic                        bready,
  input  logic [`SHA512_ADDR_W-1:0]   araddr,
  input  logic                        arvalid,
  output logic                        arready,
  output logic [`SHA512_DATA_W-1:0]   rdata,
  output axil_resp_t                  rresp,
  output logic                        rvalid,
  input  logic                        rready,
  sha512_core_if.regs                 bus
);

  logic [`SHA512_DATA_W-1:0] blk_q [`SHA512_BLOCK_WORDS];
  sha512_mode_t              mode_q;
  logic                      init_q;
  logic                      next_q;
  logic                      wr_fire;
  logic                      rd_fire;
  logic [`SHA512_ADDR_W-3:0] wr_idx;
  logic [`SHA512_ADDR_W-3:0] rd_idx;
  logic                      wr_is_blk;
  logic                      rd_is_blk;
  logic                      rd_is_dig;
  logic [4:0]                wr_blk;
  logic [4:0]                rd_blk;
  logic [3:0]                rd_dig;
  logic [`SHA512_DATA_W-1:0] rd_word;
  axil_resp_t                rd_resp;

  assign wr_fire = awvalid && wvalid && !bvalid;
  assign rd_fire = arvalid && !rvalid;
  assign awready = wr_fire;
  assign wready  = wr_fire;
  assign arready = rd_fire;

  assign wr_idx    = awaddr[`SHA512_ADDR_W-1:2];
  assign rd_idx    = araddr[`SHA512_ADDR_W-1:2];
  assign wr_is_blk = (wr_idx >= reg_block_lo) && (wr_idx <= reg_block_hi);
  assign rd_is_blk = (rd_idx >= reg_block_lo) && (rd_idx <= reg_block_hi);
  assign rd_is_dig = (rd_idx >= reg_digest_lo) && (rd_idx <= reg_digest_hi);
  assign wr_blk    = 5'(wr_idx - reg_block_lo);
  assign rd_blk    = 5'(rd_idx - reg_block_lo);
  assign rd_dig    = 4'(rd_idx - reg_digest_lo);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      bvalid <= 1'b0;
      init_q <= 1'b0;
      next_q <= 1'b0;
      mode_q <= mode_512;
    end
    else
    begin
      init_q <= 1'b0;
      next_q <= 1'b0;
      if (bvalid && bready)
        bvalid <= 1'b0;
      if (wr_fire)
      begin
        bvalid <= 1'b1;
        if (wr_idx == reg_ctrl)
        begin
          mode_q <= sha512_mode_t'(wdata[3:2]);
          // a start while the core is busy is dropped. init wins over next.
          if (bus.ready)
          begin
            init_q <= wdata[0];
            next_q <= wdata[1] & ~wdata[0];
          end
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_fire)
    begin
      if (wr_is_blk || wr_idx == reg_ctrl || wr_idx == reg_status ||
          (wr_idx >= reg_digest_lo && wr_idx <= reg_digest_hi))
        bresp <= axil_okay;
      else
        bresp <= axil_slverr;
      if (wr_is_blk)
        for (int b = 0; b < `SHA512_DATA_W/8; b++)
          if (wstrb[b])
            blk_q[wr_blk][8*b +: 8] <= wdata[8*b +: 8];
    end
  end

  always_comb
  begin
    rd_word = '0;
    rd_resp = axil_okay;
    if (rd_idx == reg_ctrl)
      rd_word[3:2] = mode_q;
    else if (rd_idx == reg_status)
      rd_word[1:0] = {bus.digest_valid, bus.ready};
    else if (rd_is_blk)
      rd_word = blk_q[rd_blk];
    else if (rd_is_dig)
      rd_word = bus.digest[(4'd15 - rd_dig)*`SHA512_DATA_W +: `SHA512_DATA_W];
    else
      rd_resp = axil_slverr;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      rvalid <= 1'b0;
    else if (rd_fire)
      rvalid <= 1'b1;
    else if (rready)
      rvalid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (rd_fire)
    begin
      rdata <= rd_word;
      rresp <= rd_resp;
    end
  end

  // word 0 is the most significant.
  always_comb
  begin
    for (int i = 0; i < `SHA512_BLOCK_WORDS; i++)
      bus.block[(`SHA512_BLOCK_WORDS-1-i)*`SHA512_DATA_W +: `SHA512_DATA_W] = blk_q[i];
  end

  assign bus.mode = mode_q;
  assign bus.init = init_q;
  assign bus.next = next_q;

  a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid && $stable(bresp));

  a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

`default_nettype wire

// File: hdl/sha512_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "sha512_cfg.svh"

module sha512_top
  import sha512_axil_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [`SHA512_ADDR_W-1:0]   awaddr,
  input  logic                        awvalid,
  output logic                        awready,
  input  logic [`SHA512_DATA_W-1:0]   wdata,
  input  logic [`SHA512_DATA_W/8-1:0] wstrb,
  input  logic                        wvalid,
  output logic                        wready,
  output axil_resp_t                  bresp,
  output logic                        bvalid,
  input  logic                        bready,
  input  logic [`SHA512_ADDR_W-1:0]   araddr,
  input  logic                        arvalid,
  output logic                        arready,
  output logic [`SHA512_DATA_W-1:0]   rdata,
  output axil_resp_t                  rresp,
  output logic                        rvalid,
  input  logic                        rready
);

  sha512_core_if core_bus ();

  sha512_axil_regs u_regs (
    .clk    (clk),
    .rst_n  (rst_n),
    .awaddr (awaddr),
    .awvalid(awvalid),
    .awready(awready),
    .wdata  (wdata),
    .wstrb  (wstrb),
    .wvalid (wvalid),
    .wready (wready),
    .bresp  (bresp),
    .bvalid (bvalid),
    .bready (bready),
    .araddr (araddr),
    .arvalid(arvalid),
    .arready(arready),
    .rdata  (rdata),
    .rresp  (rresp),
    .rvalid (rvalid),
    .rready (rready),
    .bus    (core_bus.regs)
  );

  sha512_core u_core (
    .clk  (clk),
    .rst_n(rst_n),
    .bus  (core_bus.core)
  );

endmodule

`default_nettype wire

// File: verification/tb_sha512.sv
`timescale 1ns/100ps
`default_nettype none

`include "sha512_cfg.svh"

module tb_sha512
  import sha512_pkg::*;
  import sha512_axil_pkg::*;
();

  localparam int n_cases    = 6;
  localparam int wait_limit = 200;

  logic                        clk;
  logic                        rst_n;
  logic [`SHA512_ADDR_W-1:0]   awaddr;
  logic                        awvalid;
  logic                        awready;
  logic [`SHA512_DATA_W-1:0]   wdata;
  logic [`SHA512_DATA_W/8-1:0] wstrb;
  logic                        wvalid;
  logic                        wready;
  axil_resp_t                  bresp;
  logic                        bvalid;
  logic                        bready;
  logic [`SHA512_ADDR_W-1:0]   araddr;
  logic                        arvalid;
  logic                        arready;
  logic [`SHA512_DATA_W-1:0]   rdata;
  axil_resp_t                  rresp;
  logic                        rvalid;
  logic                        rready;

  logic [31:0] lfsr_q;
  logic [31:0] blk_tab [3][32];

  // FIPS 180-4 examples. block 0 holds "abc" and blocks 1 and 2 the 896-bit message.
  sha512_mode_t   case_mode  [n_cases] = '{mode_224, mode_256, mode_384, mode_512,
                                           mode_512, mode_384};
  int             case_first [n_cases] = '{0, 0, 0, 0, 1, 1};
  int             case_nblk  [n_cases] = '{1, 1, 1, 1, 2, 2};
  sha512_digest_t case_digest[n_cases] = '{
    {64'h4634270f707b6a54, 64'hdaae7530460842e2, 64'h0e37ed265ceee9a4, 32'h3e8924aa, 288'h0},
    {64'h53048e2681941ef9, 64'h9b2e29b76b4c7dab, 64'he4c2d0c634fc6d46, 64'he0e2f13107e7af23,
     256'h0},
    {64'hcb00753f45a35e8b, 64'hb5a03d699ac65007, 64'h272c32ab0eded163, 64'h1a8b605a43ff5bed,
     64'h8086072ba1e7cc23, 64'h58baeca134c825a7, 128'h0},
    {64'hddaf35a193617aba, 64'hcc417349ae204131, 64'h12e6fa4e89a97ea2, 64'h0a9eeee64b55d39a,
     64'h2192992a274fc1a8, 64'h36ba3c23a3feebbd, 64'h454d4423643ce80e, 64'h2a9ac94fa54ca49f},
    {64'h8e959b75dae313da, 64'h8cf4f72814fc143f, 64'h8f7779c6eb9f7fa1, 64'h7299aeadb6889018,
     64'h501d289e4900f7e4, 64'h331b99dec4b5433a, 64'hc7d329eeb6dd2654, 64'h5e96e55b874be909},
    {64'h09330c33f71147e8, 64'h3d192fc782cd1b47, 64'h53111b173b3b05d2, 64'h2fa08086e3b0f712,
     64'hfcc7c71a557e2db9, 64'h66c3e9fa91746039, 128'h0}
  };
  int bad_tab [4] = '{0, 10, 50, 255};

  sha512_top dut0 (
    .clk    (clk),
    .rst_n  (rst_n),
    .awaddr (awaddr),
    .awvalid(awvalid),
    .awready(awready),
    .wdata  (wdata),
    .wstrb  (wstrb),
    .wvalid (wvalid),
    .wready (wready),
    .bresp  (bresp),
    .bvalid (bvalid),
    .bready (bready),
    .araddr (araddr),
    .arvalid(arvalid),
    .arready(arready),
    .rdata  (rdata),
    .rresp  (rresp),
    .rvalid (rvalid),
    .rready (rready)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stop_run();
    $display("Done: errors found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input logic [`SHA512_DATA_W-1:0] got,
                            input logic [`SHA512_DATA_W-1:0] exp, input string what);
    if (got !== exp)
    begin
      $display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_resp(input axil_resp_t got, input axil_resp_t exp, input string what);
    if (got !== exp)
    begin
      $display("** Error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_digest(input sha512_digest_t got, input sha512_digest_t exp,
                              input string what);
    if (got !== exp)
    begin
      $display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  // galois form with the polynomial x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++)
    begin
      val = (val << 1) | int'(lfsr_q[0]);
      lfsr_q = lfsr_step(lfsr_q);
    end
  endtask

  function automatic logic [31:0] four_chars(input int first);
    return {8'(first), 8'(first + 1), 8'(first + 2), 8'(first + 3)};
  endfunction

  task automatic build_blocks();
    for (int b = 0; b < 3; b++)
      for (int i = 0; i < 32; i++)
        blk_tab[b][i] = '0;
    blk_tab[0][0]  = 32'h61626380;
    blk_tab[0][31] = 32'h00000018;
    // fourteen groups of eight letters that each start one letter further on.
    for (int g = 0; g < 14; g++)
    begin
      blk_tab[1][2*g]   = four_chars(8'h61 + g);
      blk_tab[1][2*g+1] = four_chars(8'h65 + g);
    end
    blk_tab[1][28] = 32'h80000000;
    blk_tab[2][31] = 32'h00000380;
  endtask

  task automatic axi_write(input int word, input logic [31:0] data, input logic [3:0] strb,
                           output axil_resp_t resp);
    int n;
    int delay;
    @(negedge clk);
    awaddr  = `SHA512_ADDR_W'(word * 4);
    awvalid = 1'b1;
    wdata   = data;
    wstrb   = strb;
    wvalid  = 1'b1;
    #1;
    n = 0;
    while (!(awready && wready))
    begin
      n++;
      if (n > wait_limit)
      begin
        $display("timeout: write to word %0d was never accepted", word);
        stop_run();
      end
      @(negedge clk);
      #1;
    end
    @(posedge clk);
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    n = 0;
    while (!bvalid)
    begin
      n++;
      if (n > wait_limit)
      begin
        $display("timeout: no write response for word %0d", word);
        stop_run();
      end
      @(negedge clk);
    end
    resp = bresp;
    take_bits(2, delay);
    repeat (delay)
    begin
      @(negedge clk);
      if (!bvalid)
      begin
        $display("write response for word %0d dropped before bready", word);
        stop_run();
      end
      check_resp(bresp, resp, "bresp while held");
    end
    bready = 1'b1;
    @(posedge clk);
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axi_read(input int word, output logic [31:0] data, output axil_resp_t resp);
    int n;
    int delay;
    @(negedge clk);
    araddr  = `SHA512_ADDR_W'(word * 4);
    arvalid = 1'b1;
    #1;
    n = 0;
    while (!arready)
    begin
      n++;
      if (n > wait_limit)
      begin
        $display("timeout: read of word %0d was never accepted", word);
        stop_run();
      end
      @(negedge clk);
      #1;
    end
    @(posedge clk);
    @(negedge clk);
    arvalid = 1'b0;
    n = 0;
    while (!rvalid)
    begin
      n++;
      if (n > wait_limit)
      begin
        $display("timeout: no read data for word %0d", word);
        stop_run();
      end
      @(negedge clk);
    end
    data = rdata;
    resp = rresp;
    take_bits(2, delay);
    repeat (delay)
    begin
      @(negedge clk);
      if (!rvalid)
      begin
        $display("read data for word %0d dropped before rready", word);
        stop_run();
      end
      check_word(rdata, data, "rdata while held");
      check_resp(rresp, resp, "rresp while held");
    end
    rready = 1'b1;
    @(posedge clk);
    @(negedge clk);
    rready = 1'b0;
  endtask

  task automatic write_ok(input int word, input logic [31:0] data);
    axil_resp_t resp;
    axi_write(word, data, 4'hf, resp);
    check_resp(resp, axil_okay, "write response");
  endtask

  task automatic read_expect(input int word, input logic [31:0] exp, input axil_resp_t exp_resp,
                             input string what);
    logic [31:0] data;
    axil_resp_t  resp;
    axi_read(word, data, resp);
    check_word(data, exp, what);
    check_resp(resp, exp_resp, what);
  endtask

  task automatic load_block(input int idx);
    for (int i = 0; i < 32; i++)
      write_ok(reg_block_lo + i, blk_tab[idx][i]);
  endtask

  task automatic wait_hash_done();
    logic [31:0] st;
    axil_resp_t  resp;
    int          n;
    n = 0;
    axi_read(reg_status, st, resp);
    while (st[1:0] != 2'b11)
    begin
      n++;
      if (n > wait_limit)
      begin
        $display("timeout: hash never reported ready with a valid digest");
        stop_run();
      end
      axi_read(reg_status, st, resp);
    end
    check_resp(resp, axil_okay, "status response");
  endtask

  task automatic read_digest(output sha512_digest_t d);
    logic [31:0] data;
    axil_resp_t  resp;
    for (int i = 0; i < 16; i++)
    begin
      axi_read(reg_digest_lo + i, data, resp);
      check_resp(resp, axil_okay, "digest response");
      d[511 - 32*i -: 32] = data;
    end
  endtask

  initial
  begin
    sha512_digest_t dig;
    axil_resp_t     resp;
    rst_n   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    lfsr_q  = 32'h13716e6e;
    build_blocks();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    read_expect(reg_status, 32'h1, axil_okay, "status after reset");

    for (int i = 0; i < 4; i++)
    begin
      read_expect(bad_tab[i], 32'h0, axil_slverr, "unmapped read");
      axi_write(bad_tab[i], 32'hdeadbeef, 4'hf, resp);
      check_resp(resp, axil_slverr, "unmapped write response");
    end

    // byte strobes on a block word.
    write_ok(reg_block_lo + 5, 32'ha5a5a5a5);
    axi_write(reg_block_lo + 5, 32'h11223344, 4'b0101, resp);
    check_resp(resp, axil_okay, "strobed write response");
    read_expect(reg_block_lo + 5, 32'ha522a544, axil_okay, "strobed block word");

    for (int c = 0; c < n_cases; c++)
    begin
      load_block(case_first[c]);
      write_ok(reg_ctrl, {28'h0, case_mode[c], 2'b01});
      read_expect(reg_status, 32'h0, axil_okay, "status right after start");
      // the core already holds the block, so a restart here would change the digest.
      write_ok(reg_block_lo, 32'h0);
      write_ok(reg_ctrl, {28'h0, case_mode[c], 2'b01});
      wait_hash_done();
      if (case_nblk[c] == 2)
      begin
        load_block(case_first[c] + 1);
        write_ok(reg_ctrl, {28'h0, case_mode[c], 2'b10});
        wait_hash_done();
      end
      read_digest(dig);
      check_digest(dig, case_digest[c], "digest");
    end

    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+hdl
hdl/sha512_pkg.sv
hdl/sha512_axil_pkg.sv
hdl/sha512_core_if.sv
hdl/sha512_h_constants.sv
hdl/sha512_k_constants.sv
hdl/sha512_w_mem.sv
hdl/sha512_core.sv
hdl/sha512_axil_regs.sv
hdl/sha512_top.sv
verification/tb_sha512.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_sha512 -Mdir obj_dir &&
./obj_dir/Vtb_sha512 | grep -F "Done: no errors" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
